// ==== flist.f ====
src/icache_dir_pkg.sv
src/one_hot_shift_reg.sv
src/icache_replacement_block.sv
src/icache_tag_lookup.sv
src/icache_dir_ctrl.sv
src/icache_dir_top.sv
sim/tb_clk_gen.sv
sim/icache_dir_asserts.sv
sim/icache_dir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the tag directory testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module icache_dir_tb -Mdir obj_dir -f flist.f \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vicache_dir_tb > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -q "^Testbench passed$" sim.log && echo "Result: PASS" || { echo "Result: FAIL"; exit 1; }

// ==== sim/icache_dir_tb.sv ====
// ########################################
// Testbench for the instruction cache tag directory
// Drives lookups and flushes over Wishbone, predicts
// every response with a reference model and compares
// ########################################

`timescale 1ns/1ps

module icache_dir_tb;

  typedef logic [icache_dir_pkg::TAG_W-1:0] tag_t;
  typedef logic [icache_dir_pkg::SET_W-1:0] set_t;
  typedef logic [icache_dir_pkg::DAT_W-1:0] word_t;

  logic                              clk;
  logic                              rst_n;
  logic                              wb_cyc;
  logic                              wb_stb;
  logic                              wb_we;
  logic [icache_dir_pkg::ADDR_W-1:0] wb_adr;
  word_t                             wb_dat_w;
  word_t                             wb_dat_r;
  logic                              wb_ack;

  // Reference model state: tags, valid bits and the way pointer
  tag_t                             model_tag [icache_dir_pkg::N_SET][icache_dir_pkg::N_WAY];
  logic [icache_dir_pkg::N_WAY-1:0] model_valid [icache_dir_pkg::N_SET];
  int                               model_ptr;

  // Finished transfers waiting for the comparing process
  word_t exp_q [$];
  word_t got_q [$];
  int    lat_q [$];

  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  int     test_err_base;
  integer seed;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  icache_dir_top icache_dir_top_inst (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  // Response layout: hit flag at the bottom, way number right above it
  function automatic word_t rsp_word(input logic hit, input int way);
    word_t w;
    w = '0;
    w[icache_dir_pkg::RSP_HIT_BIT] = hit;
    w[icache_dir_pkg::RSP_WAY_LSB +: icache_dir_pkg::WAY_W] = way[icache_dir_pkg::WAY_W-1:0];
    return w;
  endfunction

  function automatic logic [icache_dir_pkg::ADDR_W-1:0] line_addr(
    input tag_t tag, input set_t set_idx, input logic [icache_dir_pkg::OFFSET_W-1:0] off);
    return {tag, set_idx, off};
  endfunction

  // Model of the directory, updated in request order
  function automatic word_t expected_response(input logic we,
                                              input logic [icache_dir_pkg::ADDR_W-1:0] addr);
    set_t set_idx;
    tag_t tag;
    logic hit;
    int   way;
    set_idx = addr[icache_dir_pkg::OFFSET_W +: icache_dir_pkg::SET_W];
    tag     = addr[icache_dir_pkg::ADDR_W-1 -: icache_dir_pkg::TAG_W];
    hit     = 1'b0;
    way     = 0;
    if (we) begin
      // A flush drops every line and answers with zero
      for (int s = 0; s < icache_dir_pkg::N_SET; s++) begin
        model_valid[s] = '0;
      end
      return '0;
    end
    for (int w = 0; w < icache_dir_pkg::N_WAY; w++) begin
      if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    // The pointer rotates on every read, hit or miss
    model_ptr = (model_ptr + 1) % icache_dir_pkg::N_WAY;
    if (!hit) begin
      // Lowest invalid way wins, else the pointer after this rotation
      way = model_ptr;
      for (int w = icache_dir_pkg::N_WAY - 1; w >= 0; w--) begin
        if (!model_valid[set_idx][w]) begin
          way = w;
        end
      end
      model_tag[set_idx][way]   = tag;
      model_valid[set_idx][way] = 1'b1;
    end
    return rsp_word(hit, way);
  endfunction

  // One Wishbone classic transfer, entered 1 ns after a rising edge
  task automatic bus_cycle(input logic we, input logic [icache_dir_pkg::ADDR_W-1:0] addr,
                           output word_t rsp);
    word_t exp_w;
    int    cycles;
    exp_w    = expected_response(we, addr);
    rsp      = '0;
    cycles   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_dat_w = '0;
    // Ack is looked at 1 ns past each edge, where it is stable
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (wb_ack !== 1'b1 && cycles < 20);
    if (wb_ack !== 1'b1) begin
      $display("Timeout: no ack within 20 cycles, we=%0b address 0x%08h", we, addr);
      err_cnt++;
    end else begin
      rsp = wb_dat_r;
      exp_q.push_back(exp_w);
      got_q.push_back(wb_dat_r);
      // The first edge counted is the accepting one
      lat_q.push_back(cycles - 1);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name);
    int cycles;
    cycles = 0;
    while (got_q.size() > 0 && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (got_q.size() > 0) begin
      $display("Responses of %s were never compared", name);
      err_cnt++;
    end
    test_cnt++;
    $display("Test %0d (%s) done with %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  always @(posedge clk) begin : compare_proc
    word_t exp_w;
    word_t got_w;
    int    lat;
    if (got_q.size() > 0) begin
      exp_w = exp_q.pop_front();
      got_w = got_q.pop_front();
      lat   = lat_q.pop_front();
      check_cnt++;
      if (got_w !== exp_w) begin
        $display("** Error at %0t: response 0x%08h, model expects 0x%08h", $time, got_w, exp_w);
        err_cnt++;
      end
      if (lat != 2) begin
        $display("** Error at %0t: ack %0d cycles after acceptance, expected 2", $time, lat);
        err_cnt++;
      end
    end
  end

  initial begin : stimulus
    word_t rsp;
    word_t rnd;
    tag_t  tag_base;
    tag_t  tag_v;
    set_t  set_v;
    int    victim;
    int    wait_cycles;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    test_err_base = 0;
    seed          = 32'h516d1d13;
    model_ptr     = 0;
    tag_base      = tag_t'(32'h000a_1b00);
    for (int s = 0; s < icache_dir_pkg::N_SET; s++) begin
      model_valid[s] = '0;
      for (int w = 0; w < icache_dir_pkg::N_WAY; w++) begin
        model_tag[s][w] = '0;
      end
    end
    wait_cycles = 0;
    while (rst_n !== 1'b1 && wait_cycles < 20) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      err_cnt++;
    end
    @(posedge clk);
    #1;

    // Empty set fills in way order
    for (int i = 0; i < 4; i++) begin
      bus_cycle(1'b0, line_addr(tag_base + tag_t'(i), set_t'(3), '0), rsp);
      check_cnt++;
      if (rsp !== rsp_word(1'b0, i)) begin
        $display("** Error at %0t: fill %0d got 0x%08h, expected miss in way %0d", $time, i, rsp, i);
        err_cnt++;
      end
    end
    end_test("fill empty set");

    for (int i = 0; i < 4; i++) begin
      bus_cycle(1'b0, line_addr(tag_base + tag_t'(i), set_t'(3), 4'h8), rsp);
      check_cnt++;
      if (rsp !== rsp_word(1'b1, i)) begin
        $display("** Error at %0t: repeat %0d got 0x%08h, expected hit in way %0d", $time, i, rsp, i);
        err_cnt++;
      end
    end
    end_test("hit on refetch");

    // Full set, the victim comes from the rotated pointer
    bus_cycle(1'b0, line_addr(tag_base + tag_t'(4), set_t'(3), '0), rsp);
    victim = model_ptr;
    bus_cycle(1'b0, line_addr(tag_base + tag_t'(victim), set_t'(3), '0), rsp);
    check_cnt++;
    if (rsp[icache_dir_pkg::RSP_HIT_BIT] !== 1'b0) begin
      $display("** Error at %0t: evicted line of way %0d still hits", $time, victim);
      err_cnt++;
    end
    end_test("evict from full set");

    bus_cycle(1'b1, '0, rsp);
    check_cnt++;
    if (rsp !== '0) begin
      $display("** Error at %0t: flush returned 0x%08h instead of zero", $time, rsp);
      err_cnt++;
    end
    for (int i = 0; i < 4; i++) begin
      bus_cycle(1'b0, line_addr(tag_base + tag_t'(i), set_t'(3), '0), rsp);
      check_cnt++;
      if (rsp !== rsp_word(1'b0, i)) begin
        $display("** Error at %0t: after flush got 0x%08h, expected miss in way %0d", $time, rsp, i);
        err_cnt++;
      end
    end
    end_test("flush");

    // Six tags over four sets keep both hits and evictions frequent
    for (int n = 0; n < 200; n++) begin
      rnd   = $random(seed);
      tag_v = tag_base + tag_t'(rnd[31:16] % 16'd6);
      set_v = set_t'({rnd[9:8], 2'b01});
      bus_cycle(1'b0, line_addr(tag_v, set_v, rnd[icache_dir_pkg::OFFSET_W-1:0]), rsp);
    end
    end_test("random reads");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sim/icache_dir_asserts.sv ====
// ########################################
// Concurrent checks on the directory controller
// Ack is a single pulse at a fixed distance from
// acceptance and the victim vector is one-hot
// ########################################

`timescale 1ns/1ps

module icache_dir_asserts (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             accept_i,
  input logic                             wb_ack_i,
  input logic [icache_dir_pkg::N_WAY-1:0] replace_vec_i
);

  // Ack never stays up for a second cycle
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |=> !wb_ack_i)
    else $error("ack stayed high for more than one cycle");

  // Ack is set at edge 2 and therefore sampled high at the third edge after acceptance
  ack_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i |-> ##3 wb_ack_i)
    else $error("no ack two cycles after an accepted request");

  // Every ack belongs to a request accepted at the matching edge
  ack_has_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(wb_ack_i) |-> $past(accept_i, 3))
    else $error("ack without a request accepted two cycles before");

  victim_one_hot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot(replace_vec_i))
    else $error("victim vector is not one-hot");

endmodule

bind icache_dir_ctrl icache_dir_asserts i_dir_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .accept_i      (accept),
  .wb_ack_i      (wb_ack_o),
  .replace_vec_i (replace_vec_i)
);

// ==== sim/tb_clk_gen.sv ====
// ########################################
// Testbench clock and reset generator
// 8 ns clock, active-low reset held for
// the first five rising edges
// ########################################

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset lets go 1 ns after the fifth edge, the same offset as the bus inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== src/icache_dir_top.sv ====
// #####################################
// Instruction cache tag directory
// Wishbone classic slave that answers fetch
// lookups with a hit flag and a way number
// #####################################

`timescale 1ns/1ps

module icache_dir_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Wishbone classic slave port
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [icache_dir_pkg::ADDR_W-1:0] wb_adr_i,
  // Write data has no meaning for a flush, it only completes the bus
  input  logic [icache_dir_pkg::DAT_W-1:0]  wb_dat_i,
  output logic [icache_dir_pkg::DAT_W-1:0]  wb_dat_o,
  output logic                              wb_ack_o
);

  logic [icache_dir_pkg::N_WAY-1:0] hit_vec;
  logic [icache_dir_pkg::N_WAY-1:0] valid_vec;
  logic [icache_dir_pkg::N_WAY-1:0] replace_vec;
  logic [icache_dir_pkg::N_WAY-1:0] way_sel;
  logic                             update_replacement;
  logic                             tag_we;
  logic                             flush;

  // Set and tag come straight from the bus, the master holds the address
  icache_tag_lookup i_tag_lookup (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .addr_i      (wb_adr_i),
    .tag_we_i    (tag_we),
    .way_sel_i   (way_sel),
    .flush_i     (flush),
    .hit_vec_o   (hit_vec),
    .valid_vec_o (valid_vec)
  );

  // Works beside the lookup on the same valid vector
  icache_replacement_block i_replacement_block (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .valid_vec_i          (valid_vec),
    .update_replacement_i (update_replacement),
    .replace_vec_o        (replace_vec)
  );

  icache_dir_ctrl i_dir_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .wb_cyc_i             (wb_cyc_i),
    .wb_stb_i             (wb_stb_i),
    .wb_we_i              (wb_we_i),
    .wb_ack_o             (wb_ack_o),
    .wb_dat_o             (wb_dat_o),
    .hit_vec_i            (hit_vec),
    .replace_vec_i        (replace_vec),
    .update_replacement_o (update_replacement),
    .tag_we_o             (tag_we),
    .way_sel_o            (way_sel),
    .flush_o              (flush)
  );

endmodule

// ==== src/icache_dir_ctrl.sv ====
// #####################################
// Directory controller on a Wishbone classic slave
// Steps through accept, lookup and acknowledge,
// allocates the victim way on a miss, flushes on
// a write cycle and builds the response word
// #####################################

`timescale 1ns/1ps

module icache_dir_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Wishbone classic slave side
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  output logic                             wb_ack_o,
  output logic [icache_dir_pkg::DAT_W-1:0] wb_dat_o,
  // Lookup result of the addressed set
  input  logic [icache_dir_pkg::N_WAY-1:0] hit_vec_i,
  // Victim way from the replacement block
  input  logic [icache_dir_pkg::N_WAY-1:0] replace_vec_i,
  output logic                             update_replacement_o,
  // Tag write and flush toward the lookup
  output logic                             tag_we_o,
  output logic [icache_dir_pkg::N_WAY-1:0] way_sel_o,
  output logic                             flush_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOK,
    ST_ACK
  } state_e;

  state_e state_q;
  state_e state_d;

  logic                             accept;
  logic                             we_q;
  logic                             hit_q;
  logic [icache_dir_pkg::WAY_W-1:0] hit_way_q;
  logic [icache_dir_pkg::WAY_W-1:0] victim_way;
  logic [icache_dir_pkg::DAT_W-1:0] rsp_d;

  // Turns a one-hot way vector into its index
  function automatic logic [icache_dir_pkg::WAY_W-1:0] onehot_to_idx(
    input logic [icache_dir_pkg::N_WAY-1:0] vec
  );
    logic [icache_dir_pkg::WAY_W-1:0] idx;
    idx = '0;
    for (int k = 0; k < icache_dir_pkg::N_WAY; k++) begin
      if (vec[k]) begin
        idx = k[icache_dir_pkg::WAY_W-1:0];
      end
    end
    return idx;
  endfunction

  // A request is taken only from idle and never while the previous ack is out
  // This keeps a master that is still holding stb from being served twice
  assign accept = (state_q == ST_IDLE) && wb_cyc_i && wb_stb_i && !wb_ack_o;

  // Every read moves the pointer, whether it hits or not
  assign update_replacement_o = accept && !wb_we_i;

  // Fixed sequence, so the latency is the same for reads and flushes
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (accept) state_d = ST_LOOK;
      ST_LOOK: state_d = ST_ACK;
      ST_ACK:  state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // State and request flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      we_q    <= 1'b0;
      hit_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        we_q  <= wb_we_i;
        hit_q <= |hit_vec_i;
      end
    end
  end

  // The hitting way is encoded right at acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hit_way_q <= onehot_to_idx(hit_vec_i);
    end
  end

  // The victim is stable from the cycle after acceptance on
  assign victim_way = onehot_to_idx(replace_vec_i);

  // A read miss allocates the victim way in the last cycle of the sequence
  assign tag_we_o  = (state_q == ST_ACK) && !we_q && !hit_q;
  assign way_sel_o = replace_vec_i;

  // A write cycle drops every line at the same edge
  assign flush_o = (state_q == ST_ACK) && we_q;

  // Response word, zero for a flush
  always_comb begin
    rsp_d = '0;
    if (!we_q) begin
      rsp_d[icache_dir_pkg::RSP_HIT_BIT] = hit_q;
      rsp_d[icache_dir_pkg::RSP_WAY_LSB +: icache_dir_pkg::WAY_W] = hit_q ? hit_way_q : victim_way;
    end
  end

  // Ack and data are registered so both show up right after the write edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else if (state_q == ST_ACK) begin
      wb_ack_o <= 1'b1;
      wb_dat_o <= rsp_d;
    end else begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end
  end

endmodule

// ==== src/icache_tag_lookup.sv ====
// #####################################
// Tag and valid storage of the directory
// Combinational lookup of the indexed set with
// a per-way compare, one tag write port and a
// flush that clears every valid bit at once
// #####################################

`timescale 1ns/1ps

module icache_tag_lookup (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Fetch address, held stable by the bus master
  input  logic [icache_dir_pkg::ADDR_W-1:0] addr_i,
  // Tag write into the selected ways of the indexed set
  input  logic                              tag_we_i,
  input  logic [icache_dir_pkg::N_WAY-1:0]  way_sel_i,
  // Invalidate the whole directory
  input  logic                              flush_i,
  // Lookup results for the indexed set
  output logic [icache_dir_pkg::N_WAY-1:0]  hit_vec_o,
  output logic [icache_dir_pkg::N_WAY-1:0]  valid_vec_o
);

  // Tag array, one entry per set and way
  logic [icache_dir_pkg::TAG_W-1:0] tag_mem_q [icache_dir_pkg::N_SET][icache_dir_pkg::N_WAY];

  // Valid bits, packed so that a flush clears them in one assignment
  logic [icache_dir_pkg::N_SET-1:0][icache_dir_pkg::N_WAY-1:0] valid_q;

  logic [icache_dir_pkg::SET_W-1:0] set_idx;
  logic [icache_dir_pkg::TAG_W-1:0] addr_tag;

  // Address split: the tag on top, then the set, then the line offset
  assign set_idx  = addr_i[icache_dir_pkg::OFFSET_W +: icache_dir_pkg::SET_W];
  assign addr_tag = addr_i[icache_dir_pkg::ADDR_W-1 -: icache_dir_pkg::TAG_W];

  assign valid_vec_o = valid_q[set_idx];

  // A way hits only if its entry is valid and the stored tag matches
  always_comb begin
    for (int w = 0; w < icache_dir_pkg::N_WAY; w++) begin
      hit_vec_o[w] = valid_q[set_idx][w] && (tag_mem_q[set_idx][w] == addr_tag);
    end
  end

  // Valid bits, flush takes priority over a write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (tag_we_i) begin
      valid_q[set_idx] <= valid_q[set_idx] | way_sel_i;
    end
  end

  // Tag storage, only the selected ways of the set are written
  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      for (int w = 0; w < icache_dir_pkg::N_WAY; w++) begin
        if (way_sel_i[w]) begin
          tag_mem_q[set_idx][w] <= addr_tag;
        end
      end
    end
  end

endmodule

// ==== src/icache_replacement_block.sv ====
// #####################################
// Victim way selection for the tag directory
// Fills invalid ways first, lowest index first,
// and falls back to a rotating one-hot pointer
// once every way of the set is valid
// #####################################

`timescale 1ns/1ps

module icache_replacement_block (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Valid bits of the set being looked up
  input  logic [icache_dir_pkg::N_WAY-1:0] valid_vec_i,
  // Samples the valid vector and advances the pointer
  input  logic                             update_replacement_i,
  // One-hot victim way
  output logic [icache_dir_pkg::N_WAY-1:0] replace_vec_o
);

  logic [icache_dir_pkg::N_WAY-1:0] invalid_vec_q;
  logic [icache_dir_pkg::N_WAY-1:0] shift_q;
  logic [icache_dir_pkg::N_WAY-1:0] first_invalid;
  logic                             any_invalid;
  logic                             found;

  // Rotating pointer used once the set is full
  one_hot_shift_reg #(
    .REG_LEN (icache_dir_pkg::N_WAY)
  ) i_one_hot_shift_reg (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .update_i (update_replacement_i),
    .output_o (shift_q)
  );

  // Capture which ways were free when the request was accepted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      invalid_vec_q <= '0;
    end else if (update_replacement_i) begin
      invalid_vec_q <= ~valid_vec_i;
    end
  end

  assign any_invalid = |invalid_vec_q;

  // Priority pick of the lowest free way
  // The scan always begins at way 0
  always_comb begin
    first_invalid = '0;
    found         = 1'b0;
    for (int k = 0; k < icache_dir_pkg::N_WAY; k++) begin
      if (invalid_vec_q[k] && !found) begin
        first_invalid[k] = 1'b1;
        found            = 1'b1;
      end
    end
  end

  // A free way always wins over the pointer
  assign replace_vec_o = any_invalid ? first_invalid : shift_q;

endmodule

// ==== src/one_hot_shift_reg.sv ====
// #####################################
// One-hot rotating pointer register
// Starts at bit 0 and moves one position up
// on every update strobe, wrapping at the top
// #####################################

`timescale 1ns/1ps

module one_hot_shift_reg #(
  parameter int unsigned REG_LEN = icache_dir_pkg::N_WAY
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Advance strobe
  input  logic               update_i,
  // Current one-hot position
  output logic [REG_LEN-1:0] output_o
);

  logic [REG_LEN-1:0] shift_q;

  // Rotate toward the higher bits, the top bit wraps back to bit 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q <= REG_LEN'(1);
    end else if (update_i) begin
      shift_q <= {shift_q[REG_LEN-2:0], shift_q[REG_LEN-1]};
    end
  end

  assign output_o = shift_q;

endmodule

// ==== src/icache_dir_pkg.sv ====
// #####################################
// Instruction cache tag directory package
// Holds the cache geometry, the fetch address
// split, the bus widths and the layout of the
// response word returned on a lookup
// #####################################

package icache_dir_pkg;

  // Associativity of the cache
  localparam int unsigned N_WAY = 4;

  // Width of an encoded way number
  localparam int unsigned WAY_W = $clog2(N_WAY);

  // Number of sets and the width of the set index
  localparam int unsigned N_SET = 16;
  localparam int unsigned SET_W = $clog2(N_SET);

  // A line is 16 bytes, so the low 4 address bits select the byte
  localparam int unsigned OFFSET_W = 4;

  // Fetch address width as seen on the bus
  localparam int unsigned ADDR_W = 32;

  // Whatever is left above the set index is the tag
  localparam int unsigned TAG_W = ADDR_W - SET_W - OFFSET_W;

  // Wishbone data width
  localparam int unsigned DAT_W = 32;

  // Response word layout
  // Bit 0 carries the hit flag and the way field sits right above it
  // All remaining bits of the response are zero
  localparam int unsigned RSP_HIT_BIT = 0;
  localparam int unsigned RSP_WAY_LSB = 1;

endpackage
